// ==== src/ocl_axil_pkg.sv ====
// AXI-Lite channel types for the host register port, referenced by scoped name
package ocl_axil_pkg;

  // ------------------------------
  // Per-channel beats
  // ------------------------------
  typedef struct packed {
    logic        awvalid;
    logic [31:0] awaddr;
  } axil_aw_t;

  typedef struct packed {
    logic        wvalid;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
  } axil_w_t;

  typedef struct packed {
    logic       bvalid;
    logic [1:0] bresp;
  } axil_b_t;

  typedef struct packed {
    logic        arvalid;
    logic [31:0] araddr;
  } axil_ar_t;

  typedef struct packed {
    logic        rvalid;
    logic [31:0] rdata;
    logic [1:0]  rresp;
  } axil_r_t;

  // ------------------------------
  // Bundles by driving side
  // ------------------------------
  // Host side drives requests and response readies
  typedef struct packed {
    axil_aw_t aw;
    axil_w_t  w;
    axil_ar_t ar;
    logic     bready;
    logic     rready;
  } axil_mosi_t;

  // Slave side drives responses and request readies
  typedef struct packed {
    axil_b_t b;
    axil_r_t r;
    logic    awready;
    logic    wready;
    logic    arready;
  } axil_miso_t;

endpackage

// ==== src/ocl_cfg_pkg.sv ====
// Configuration bus types, slot map and register offsets shared by the slave and banks
package ocl_cfg_pkg;

  // ------------------------------
  // Bus types
  // ------------------------------
  // wr and rd are one-cycle pulses, addr and wdata held until ack
  typedef struct packed {
    logic [31:0] addr;
    logic [31:0] wdata;
    logic        wr;
    logic        rd;
  } cfg_req_t;

  // ack lasts one cycle, rdata valid with it
  typedef struct packed {
    logic        ack;
    logic [31:0] rdata;
  } cfg_rsp_t;

  // ------------------------------
  // Slot geometry
  // ------------------------------
  // 256 bytes per slot
  localparam int SLOT_LSB = 8;
  localparam int SLOT_W   = 4;

  // Returned for slots with no bank behind them
  localparam logic [31:0] UNMAPPED_RDATA = 32'hdead_beef;

  // ------------------------------
  // Register word offsets, addr[3:2]
  // ------------------------------
  localparam logic [1:0] REG_CTRL    = 2'd0;
  localparam logic [1:0] REG_PATTERN = 2'd1;
  localparam logic [1:0] REG_COUNT   = 2'd2;
  localparam logic [1:0] REG_ID      = 2'd3;

endpackage

// ==== src/axil_reg_slice.sv ====
// Full-throughput AXI-Lite register slice with a skid entry per channel, host side to slave side
module axil_reg_slice (
  input  logic                     clk,
  input  logic                     sync_rst_n,
  input  ocl_axil_pkg::axil_mosi_t s_mosi,
  output ocl_axil_pkg::axil_miso_t s_miso,
  output ocl_axil_pkg::axil_mosi_t m_mosi,
  input  ocl_axil_pkg::axil_miso_t m_miso
);

  // Channel slots, aw/w/ar forward and b/r backward
  localparam int CH_AW  = 0;
  localparam int CH_W   = 1;
  localparam int CH_AR  = 2;
  localparam int CH_B   = 3;
  localparam int CH_R   = 4;
  localparam int NUM_CH = 5;

  // Widest payload is wdata plus wstrb
  localparam int DW = 36;

  logic [NUM_CH-1:0] in_valid;
  logic [NUM_CH-1:0] in_ready;
  logic [NUM_CH-1:0] out_valid;
  logic [NUM_CH-1:0] out_ready;
  logic [DW-1:0]     in_data [NUM_CH];
  logic [DW-1:0]     out_data [NUM_CH];

  // ------------------------------
  // Channel pack
  // ------------------------------
  always_comb
  begin
    in_valid[CH_AW] = s_mosi.aw.awvalid;
    in_data[CH_AW]  = DW'(s_mosi.aw.awaddr);
    in_valid[CH_W]  = s_mosi.w.wvalid;
    in_data[CH_W]   = {s_mosi.w.wdata, s_mosi.w.wstrb};
    in_valid[CH_AR] = s_mosi.ar.arvalid;
    in_data[CH_AR]  = DW'(s_mosi.ar.araddr);
    in_valid[CH_B]  = m_miso.b.bvalid;
    in_data[CH_B]   = DW'(m_miso.b.bresp);
    in_valid[CH_R]  = m_miso.r.rvalid;
    in_data[CH_R]   = DW'({m_miso.r.rdata, m_miso.r.rresp});

    out_ready[CH_AW] = m_miso.awready;
    out_ready[CH_W]  = m_miso.wready;
    out_ready[CH_AR] = m_miso.arready;
    out_ready[CH_B]  = s_mosi.bready;
    out_ready[CH_R]  = s_mosi.rready;
  end

  // ------------------------------
  // Per-channel main + skid stage
  // ------------------------------
  for (genvar c = 0; c < NUM_CH; c++)
  begin : g_ch
    logic          main_valid;
    logic          skid_valid;
    logic [DW-1:0] main_data;
    logic [DW-1:0] skid_data;
    logic          drain;

    // Main stage free when empty or taken downstream
    assign drain = out_ready[c] || !main_valid;

    always_ff @(posedge clk)
    begin
      if (!sync_rst_n)
      begin
        main_valid <= 1'b0;
        skid_valid <= 1'b0;
      end
      else if (drain)
      begin
        main_valid <= skid_valid || in_valid[c];
        skid_valid <= 1'b0;
      end
      else if (in_valid[c] && !skid_valid)
      begin
        skid_valid <= 1'b1;
      end
    end

    always_ff @(posedge clk)
    begin
      if (drain)
        main_data <= skid_valid ? skid_data : in_data[c];
      if (!drain && in_valid[c] && !skid_valid)
        skid_data <= in_data[c];
    end

    // Ready only looks at local state
    assign in_ready[c]  = !skid_valid;
    assign out_valid[c] = main_valid;
    assign out_data[c]  = main_data;
  end

  // ------------------------------
  // Channel unpack
  // ------------------------------
  always_comb
  begin
    m_mosi.aw.awvalid = out_valid[CH_AW];
    m_mosi.aw.awaddr  = out_data[CH_AW][31:0];
    m_mosi.w.wvalid   = out_valid[CH_W];
    m_mosi.w.wdata    = out_data[CH_W][35:4];
    m_mosi.w.wstrb    = out_data[CH_W][3:0];
    m_mosi.ar.arvalid = out_valid[CH_AR];
    m_mosi.ar.araddr  = out_data[CH_AR][31:0];
    m_mosi.bready     = in_ready[CH_B];
    m_mosi.rready     = in_ready[CH_R];

    s_miso.awready  = in_ready[CH_AW];
    s_miso.wready   = in_ready[CH_W];
    s_miso.arready  = in_ready[CH_AR];
    s_miso.b.bvalid = out_valid[CH_B];
    s_miso.b.bresp  = out_data[CH_B][1:0];
    s_miso.r.rvalid = out_valid[CH_R];
    s_miso.r.rdata  = out_data[CH_R][33:2];
    s_miso.r.rresp  = out_data[CH_R][1:0];
  end

endmodule

// ==== src/ocl_cfg_slv.sv ====
// AXI-Lite slave that serves one access at a time and turns it into config bus pulses per slot
module ocl_cfg_slv #(
  parameter int NUM_SLOTS = 16
) (
  input  logic                     clk,
  input  logic                     sync_rst_n,
  input  logic                     flr_assert,
  input  ocl_axil_pkg::axil_mosi_t host_mosi,
  output ocl_axil_pkg::axil_miso_t host_miso,
  output ocl_cfg_pkg::cfg_req_t    cfg_req [NUM_SLOTS],
  input  ocl_cfg_pkg::cfg_rsp_t    cfg_rsp [NUM_SLOTS]
);

  // Slot select covers all upper address bits
  localparam int SEL_W = 32 - ocl_cfg_pkg::SLOT_LSB;

  typedef enum logic [1:0] {
    SLV_IDLE,
    SLV_WR_ADDR,
    SLV_CYC,
    SLV_RESP
  } slv_state_t;

  slv_state_t slv_state;
  slv_state_t slv_state_nxt;

  logic                           cyc_wr;
  logic [31:0]                    req_addr;
  logic [SEL_W-1:0]               slot_sel;
  logic [ocl_cfg_pkg::SLOT_W-1:0] slot_idx;
  logic                           slot_hit;
  logic                           req_valid;
  logic                           rsp_ready;
  logic                           issue;
  logic                           did_req;
  logic                           cyc_done;
  logic [31:0]                    rdata_q;
  logic                           awready_q;
  logic                           wready_q;
  logic                           arready_q;
  logic [31:0]                    slot_addr [NUM_SLOTS];
  logic [31:0]                    slot_wdata [NUM_SLOTS];
  logic [NUM_SLOTS-1:0]           slot_wr;
  logic [NUM_SLOTS-1:0]           slot_rd;

  // ------------------------------
  // Arbitration and decode
  // ------------------------------
  // Write wins when both are waiting in idle
  always_ff @(posedge clk)
  begin
    if (slv_state == SLV_IDLE)
    begin
      if (host_mosi.aw.awvalid)
        req_addr <= host_mosi.aw.awaddr;
      else if (host_mosi.ar.arvalid)
        req_addr <= host_mosi.ar.araddr;
    end
  end

  always_ff @(posedge clk)
  begin
    if (!sync_rst_n)
      cyc_wr <= 1'b0;
    else if (slv_state == SLV_IDLE)
      cyc_wr <= host_mosi.aw.awvalid;
  end

  assign slot_sel  = req_addr[31:ocl_cfg_pkg::SLOT_LSB];
  assign slot_idx  = slot_sel[ocl_cfg_pkg::SLOT_W-1:0];
  assign slot_hit  = slot_sel < SEL_W'(NUM_SLOTS);
  assign req_valid = cyc_wr ? host_mosi.w.wvalid : 1'b1;
  assign rsp_ready = cyc_wr ? host_mosi.bready : host_mosi.rready;

  // ------------------------------
  // FSM
  // ------------------------------
  always_comb
  begin
    slv_state_nxt = slv_state;
    if (flr_assert)
      slv_state_nxt = SLV_IDLE;
    else
    begin
      case (slv_state)
        SLV_IDLE:
        begin
          if (host_mosi.aw.awvalid)
            slv_state_nxt = SLV_WR_ADDR;
          else if (host_mosi.ar.arvalid)
            slv_state_nxt = SLV_CYC;
        end
        SLV_WR_ADDR:
          slv_state_nxt = SLV_CYC;
        SLV_CYC:
        begin
          if (cyc_done)
            slv_state_nxt = SLV_RESP;
        end
        SLV_RESP:
        begin
          if (rsp_ready)
            slv_state_nxt = SLV_IDLE;
        end
        default:
          slv_state_nxt = SLV_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (!sync_rst_n)
      slv_state <= SLV_IDLE;
    else
      slv_state <= slv_state_nxt;
  end

  // ------------------------------
  // Request pulses
  // ------------------------------
  // One pulse per transaction, did_req blocks a repeat
  assign issue = (slv_state == SLV_CYC) && req_valid && !did_req;

  always_ff @(posedge clk)
  begin
    if (!sync_rst_n)
      did_req <= 1'b0;
    else if (slv_state == SLV_IDLE)
      did_req <= 1'b0;
    else if (issue)
      did_req <= 1'b1;
  end

  always_ff @(posedge clk)
  begin
    if (!sync_rst_n)
    begin
      slot_wr <= '0;
      slot_rd <= '0;
    end
    else
    begin
      for (int i = 0; i < NUM_SLOTS; i++)
      begin
        slot_wr[i] <= issue && cyc_wr && (slot_sel == SEL_W'(i));
        slot_rd[i] <= issue && !cyc_wr && (slot_sel == SEL_W'(i));
      end
    end
  end

  // Copy per slot to keep fanout local
  always_ff @(posedge clk)
  begin
    for (int i = 0; i < NUM_SLOTS; i++)
    begin
      slot_addr[i]  <= req_addr;
      slot_wdata[i] <= host_mosi.w.wdata;
    end
  end

  always_comb
  begin
    for (int i = 0; i < NUM_SLOTS; i++)
    begin
      cfg_req[i].addr  = slot_addr[i];
      cfg_req[i].wdata = slot_wdata[i];
      cfg_req[i].wr    = slot_wr[i];
      cfg_req[i].rd    = slot_rd[i];
    end
  end

  // ------------------------------
  // Completion and response
  // ------------------------------
  // Out-of-range slots finish right after the request slot
  assign cyc_done = did_req && (!slot_hit || cfg_rsp[slot_idx].ack);

  always_ff @(posedge clk)
  begin
    if ((slv_state == SLV_CYC) && cyc_done)
      rdata_q <= slot_hit ? cfg_rsp[slot_idx].rdata : ocl_cfg_pkg::UNMAPPED_RDATA;
  end

  always_ff @(posedge clk)
  begin
    if (!sync_rst_n)
    begin
      awready_q <= 1'b0;
      wready_q  <= 1'b0;
      arready_q <= 1'b0;
    end
    else
    begin
      awready_q <= slv_state_nxt == SLV_WR_ADDR;
      wready_q  <= (slv_state == SLV_CYC) && (slv_state_nxt == SLV_RESP) && cyc_wr;
      arready_q <= (slv_state == SLV_CYC) && (slv_state_nxt == SLV_RESP) && !cyc_wr;
    end
  end

  always_comb
  begin
    host_miso.awready  = awready_q;
    host_miso.wready   = wready_q;
    host_miso.arready  = arready_q;
    host_miso.b.bvalid = (slv_state == SLV_RESP) && cyc_wr;
    host_miso.b.bresp  = 2'b00;
    host_miso.r.rvalid = (slv_state == SLV_RESP) && !cyc_wr;
    host_miso.r.rdata  = rdata_q;
    host_miso.r.rresp  = 2'b00;
  end

endmodule

// ==== src/tst_cfg_regs.sv ====
// Register bank of one test block on a config bus slot, with a programmable ack delay
module tst_cfg_regs #(
  parameter int          ACK_DELAY = 0,
  parameter logic [31:0] BLOCK_ID  = 32'h0
) (
  input  logic                  clk,
  input  logic                  sync_rst_n,
  input  ocl_cfg_pkg::cfg_req_t cfg_req,
  output ocl_cfg_pkg::cfg_rsp_t cfg_rsp
);

  localparam int CNT_W = (ACK_DELAY > 0) ? $clog2(ACK_DELAY + 1) : 1;

  logic [31:0]      ctrl_q;
  logic [31:0]      pattern_q;
  logic [31:0]      count_q;
  logic [CNT_W-1:0] delay_q;
  logic [1:0]       reg_off;
  logic             pulse;

  assign reg_off = cfg_req.addr[3:2];
  assign pulse   = cfg_req.wr || cfg_req.rd;

  // ------------------------------
  // Registers
  // ------------------------------
  // COUNT bumps on every write, any offset
  always_ff @(posedge clk)
  begin
    if (!sync_rst_n)
    begin
      ctrl_q    <= '0;
      pattern_q <= '0;
      count_q   <= '0;
    end
    else if (cfg_req.wr)
    begin
      count_q <= count_q + 32'd1;
      if (reg_off == ocl_cfg_pkg::REG_CTRL)
        ctrl_q <= cfg_req.wdata;
      if (reg_off == ocl_cfg_pkg::REG_PATTERN)
        pattern_q <= cfg_req.wdata;
    end
  end

  // ------------------------------
  // Ack delay
  // ------------------------------
  always_ff @(posedge clk)
  begin
    if (!sync_rst_n)
      delay_q <= '0;
    else if (pulse)
      delay_q <= CNT_W'(ACK_DELAY);
    else if (delay_q != '0)
      delay_q <= delay_q - 1'b1;
  end

  always_comb
  begin
    case (reg_off)
      ocl_cfg_pkg::REG_CTRL:    cfg_rsp.rdata = ctrl_q;
      ocl_cfg_pkg::REG_PATTERN: cfg_rsp.rdata = pattern_q;
      ocl_cfg_pkg::REG_COUNT:   cfg_rsp.rdata = count_q;
      ocl_cfg_pkg::REG_ID:      cfg_rsp.rdata = BLOCK_ID;
    endcase
    // Zero delay acks in the pulse cycle
    cfg_rsp.ack = (ACK_DELAY == 0) ? pulse : (delay_q == CNT_W'(1));
  end

endmodule

// ==== src/cl_ocl_top.sv ====
// Top of the register access path: host AXI-Lite in, slice, slot decoder and three register banks
module cl_ocl_top (
  input  logic                     clk,
  input  logic                     sync_rst_n,
  input  logic                     flr_assert,
  input  ocl_axil_pkg::axil_mosi_t ocl_mosi,
  output ocl_axil_pkg::axil_miso_t ocl_miso
);

  localparam int NUM_SLOTS = 16;
  localparam int NUM_BANKS = 3;

  // Per-bank ack delay and identity, slots 0 to 2
  localparam int          BANK_ACK_DELAY [NUM_BANKS] = '{0, 3, 7};
  localparam logic [31:0] BANK_ID [NUM_BANKS] = '{32'h0000_a000, 32'h0000_b001, 32'h0000_c002};

  ocl_axil_pkg::axil_mosi_t ocl_mosi_q;
  ocl_axil_pkg::axil_miso_t ocl_miso_q;
  ocl_cfg_pkg::cfg_req_t    cfg_req [NUM_SLOTS];
  ocl_cfg_pkg::cfg_rsp_t    cfg_rsp [NUM_SLOTS];

  axil_reg_slice u_ocl_slice (
    .clk        (clk),
    .sync_rst_n (sync_rst_n),
    .s_mosi     (ocl_mosi),
    .s_miso     (ocl_miso),
    .m_mosi     (ocl_mosi_q),
    .m_miso     (ocl_miso_q)
  );

  ocl_cfg_slv #(
    .NUM_SLOTS (NUM_SLOTS)
  ) u_ocl_slv (
    .clk        (clk),
    .sync_rst_n (sync_rst_n),
    .flr_assert (flr_assert),
    .host_mosi  (ocl_mosi_q),
    .host_miso  (ocl_miso_q),
    .cfg_req    (cfg_req),
    .cfg_rsp    (cfg_rsp)
  );

  // ------------------------------
  // Slot population
  // ------------------------------
  for (genvar s = 0; s < NUM_SLOTS; s++)
  begin : g_slot
    if (s < NUM_BANKS)
    begin : g_bank
      tst_cfg_regs #(
        .ACK_DELAY (BANK_ACK_DELAY[s]),
        .BLOCK_ID  (BANK_ID[s])
      ) u_regs (
        .clk        (clk),
        .sync_rst_n (sync_rst_n),
        .cfg_req    (cfg_req[s]),
        .cfg_rsp    (cfg_rsp[s])
      );
    end
    else
    begin : g_unmapped
      // Empty slot acks at once
      assign cfg_rsp[s] = '{ack: 1'b1, rdata: ocl_cfg_pkg::UNMAPPED_RDATA};
    end
  end

endmodule

// ==== sim/tb_clk_gen.sv ====
// Testbench clock and synchronous reset source, reset held low for a set number of cycles
module tb_clk_gen #(
  parameter int PERIOD     = 40,
  parameter int RST_CYCLES = 5,
  parameter int DRIVE_DLY  = 2
) (
  output logic clk,
  output logic sync_rst_n
);

  initial
  begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  // Release lands just after an edge, like the other inputs
  initial
  begin
    sync_rst_n = 1'b0;
    repeat (RST_CYCLES) @(posedge clk);
    #(DRIVE_DLY) sync_rst_n = 1'b1;
  end

endmodule

// ==== sim/tb_cl_ocl.sv ====
// Table-driven testbench for the register access path, run as top with the clock generator
module tb_cl_ocl;

  localparam int          DRIVE_DLY      = 2;
  localparam int          CYCLES_PER_ROW = 400;
  localparam logic [31:0] LFSR_SEED      = 32'h21dabf84;
  localparam logic [31:0] RESP_OKAY      = 32'h0;
  localparam logic [31:0] DEAD           = 32'hdead_beef;

  typedef enum logic
  {
    OP_WR,
    OP_RD
  } op_t;

  typedef struct packed {
    op_t         op;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [31:0] exp;
    logic        flr;
  } entry_t;

  logic                     clk;
  logic                     sync_rst_n;
  logic                     flr_assert;
  ocl_axil_pkg::axil_mosi_t ocl_mosi;
  ocl_axil_pkg::axil_miso_t ocl_miso;
  entry_t                   tbl [$];
  logic                     table_loaded = 1'b0;
  logic [31:0]              lfsr_q = LFSR_SEED;

  tb_clk_gen #(
    .PERIOD     (40),
    .RST_CYCLES (5),
    .DRIVE_DLY  (DRIVE_DLY)
  ) u_clk_gen (
    .clk        (clk),
    .sync_rst_n (sync_rst_n)
  );

  cl_ocl_top DUT (
    .clk        (clk),
    .sync_rst_n (sync_rst_n),
    .flr_assert (flr_assert),
    .ocl_mosi   (ocl_mosi),
    .ocl_miso   (ocl_miso)
  );

  // ------------------------------
  // Helpers
  // ------------------------------
  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp)
    begin
      $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
      $display("Verification failed");
      $fatal(1, "value check failed");
    end
  endtask

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // Two bits with one LFSR step each
  task automatic draw_stall(output int n);
    n = 0;
    for (int i = 0; i < 2; i++)
    begin
      lfsr_q = lfsr_next(lfsr_q);
      n = (n << 1) | int'(lfsr_q[0]);
    end
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #(DRIVE_DLY);
  endtask

  task automatic pulse_flr();
    flr_assert = 1'b1;
    next_cycle();
    flr_assert = 1'b0;
    next_cycle();
  endtask

  task automatic axil_write(input logic [31:0] addr, input logic [31:0] data);
    logic aw_done;
    logic w_done;
    logic aw_go;
    logic w_go;
    int   stall;
    aw_done = 1'b0;
    w_done  = 1'b0;
    ocl_mosi.aw.awaddr  = addr;
    ocl_mosi.aw.awvalid = 1'b1;
    ocl_mosi.w.wdata    = data;
    ocl_mosi.w.wstrb    = 4'hf;
    ocl_mosi.w.wvalid   = 1'b1;
    // Ready seen now is the ready at the coming edge
    while (!(aw_done && w_done))
    begin
      aw_go = ocl_mosi.aw.awvalid && ocl_miso.awready;
      w_go  = ocl_mosi.w.wvalid && ocl_miso.wready;
      next_cycle();
      if (aw_go)
      begin
        ocl_mosi.aw.awvalid = 1'b0;
        aw_done = 1'b1;
      end
      if (w_go)
      begin
        ocl_mosi.w.wvalid = 1'b0;
        w_done = 1'b1;
      end
    end
    while (!ocl_miso.b.bvalid)
      next_cycle();
    draw_stall(stall);
    check_value("bresp", 32'(ocl_miso.b.bresp), RESP_OKAY);
    repeat (stall)
    begin
      next_cycle();
      check_value("bvalid", 32'(ocl_miso.b.bvalid), 32'd1);
      check_value("bresp", 32'(ocl_miso.b.bresp), RESP_OKAY);
    end
    ocl_mosi.bready = 1'b1;
    next_cycle();
    ocl_mosi.bready = 1'b0;
  endtask

  task automatic axil_read(input logic [31:0] addr, input logic [31:0] exp);
    logic ar_go;
    int   stall;
    ocl_mosi.ar.araddr  = addr;
    ocl_mosi.ar.arvalid = 1'b1;
    do
    begin
      ar_go = ocl_miso.arready;
      next_cycle();
    end
    while (!ar_go);
    ocl_mosi.ar.arvalid = 1'b0;
    while (!ocl_miso.r.rvalid)
      next_cycle();
    draw_stall(stall);
    check_value("rdata", ocl_miso.r.rdata, exp);
    check_value("rresp", 32'(ocl_miso.r.rresp), RESP_OKAY);
    // Response must not move while rready is low
    repeat (stall)
    begin
      next_cycle();
      check_value("rvalid", 32'(ocl_miso.r.rvalid), 32'd1);
      check_value("rdata", ocl_miso.r.rdata, exp);
      check_value("rresp", 32'(ocl_miso.r.rresp), RESP_OKAY);
    end
    ocl_mosi.rready = 1'b1;
    next_cycle();
    ocl_mosi.rready = 1'b0;
  endtask

  task automatic add_entry(input op_t op, input logic [31:0] addr, input logic [31:0] wdata,
                           input logic [31:0] exp, input logic flr);
    entry_t e;
    e = '{op: op, addr: addr, wdata: wdata, exp: exp, flr: flr};
    tbl.push_back(e);
  endtask

  // ------------------------------
  // Stimulus table
  // ------------------------------
  // Slot in addr[11:8], word in addr[3:2]; COUNT values tracked by hand per slot
  task automatic load_table();
    // Reset values
    add_entry(OP_RD, 32'h0000_000c, 32'h0, 32'h0000_a000, 1'b0);
    add_entry(OP_RD, 32'h0000_010c, 32'h0, 32'h0000_b001, 1'b0);
    add_entry(OP_RD, 32'h0000_020c, 32'h0, 32'h0000_c002, 1'b0);
    add_entry(OP_RD, 32'h0000_0000, 32'h0, 32'h0, 1'b0);
    add_entry(OP_RD, 32'h0000_0004, 32'h0, 32'h0, 1'b0);
    add_entry(OP_RD, 32'h0000_0008, 32'h0, 32'h0, 1'b0);
    add_entry(OP_RD, 32'h0000_0100, 32'h0, 32'h0, 1'b0);
    add_entry(OP_RD, 32'h0000_0104, 32'h0, 32'h0, 1'b0);
    add_entry(OP_RD, 32'h0000_0108, 32'h0, 32'h0, 1'b0);
    add_entry(OP_RD, 32'h0000_0200, 32'h0, 32'h0, 1'b0);
    add_entry(OP_RD, 32'h0000_0204, 32'h0, 32'h0, 1'b0);
    add_entry(OP_RD, 32'h0000_0208, 32'h0, 32'h0, 1'b0);
    // Read back across all three ack delays
    add_entry(OP_WR, 32'h0000_0000, 32'h1111_0000, 32'h0, 1'b0);
    add_entry(OP_WR, 32'h0000_0104, 32'h2222_0001, 32'h0, 1'b0);
    add_entry(OP_WR, 32'h0000_0200, 32'h3333_0002, 32'h0, 1'b0);
    add_entry(OP_WR, 32'h0000_0004, 32'h4444_0003, 32'h0, 1'b0);
    add_entry(OP_RD, 32'h0000_0000, 32'h0, 32'h1111_0000, 1'b0);
    add_entry(OP_RD, 32'h0000_0004, 32'h0, 32'h4444_0003, 1'b0);
    add_entry(OP_RD, 32'h0000_0100, 32'h0, 32'h0, 1'b0);
    add_entry(OP_RD, 32'h0000_0104, 32'h0, 32'h2222_0001, 1'b0);
    add_entry(OP_RD, 32'h0000_0200, 32'h0, 32'h3333_0002, 1'b0);
    add_entry(OP_RD, 32'h0000_0204, 32'h0, 32'h0, 1'b0);
    add_entry(OP_WR, 32'h0000_0100, 32'h5555_0004, 32'h0, 1'b0);
    add_entry(OP_WR, 32'h0000_0204, 32'h6666_0005, 32'h0, 1'b0);
    add_entry(OP_RD, 32'h0000_0100, 32'h0, 32'h5555_0004, 1'b0);
    add_entry(OP_RD, 32'h0000_0204, 32'h0, 32'h6666_0005, 1'b0);
    add_entry(OP_RD, 32'h0000_0000, 32'h0, 32'h1111_0000, 1'b0);
    // Write counters including writes to COUNT and ID
    add_entry(OP_RD, 32'h0000_0008, 32'h0, 32'd2, 1'b0);
    add_entry(OP_RD, 32'h0000_0108, 32'h0, 32'd2, 1'b0);
    add_entry(OP_RD, 32'h0000_0208, 32'h0, 32'd2, 1'b0);
    add_entry(OP_WR, 32'h0000_0008, 32'hffff_ffff, 32'h0, 1'b0);
    add_entry(OP_WR, 32'h0000_000c, 32'h1234_5678, 32'h0, 1'b0);
    add_entry(OP_RD, 32'h0000_0008, 32'h0, 32'd4, 1'b0);
    add_entry(OP_RD, 32'h0000_000c, 32'h0, 32'h0000_a000, 1'b0);
    add_entry(OP_WR, 32'h0000_020c, 32'h0bad_0bad, 32'h0, 1'b0);
    add_entry(OP_RD, 32'h0000_020c, 32'h0, 32'h0000_c002, 1'b0);
    add_entry(OP_RD, 32'h0000_0208, 32'h0, 32'd3, 1'b0);
    // Unmapped slots and slot fields past 15
    add_entry(OP_RD, 32'h0000_0300, 32'h0, DEAD, 1'b0);
    add_entry(OP_RD, 32'h0000_0f0c, 32'h0, DEAD, 1'b0);
    add_entry(OP_RD, 32'h0000_1000, 32'h0, DEAD, 1'b0);
    add_entry(OP_RD, 32'h8000_0004, 32'h0, DEAD, 1'b0);
    add_entry(OP_WR, 32'h0000_0300, 32'haaaa_5555, 32'h0, 1'b0);
    add_entry(OP_WR, 32'h0000_0f00, 32'h5555_aaaa, 32'h0, 1'b0);
    add_entry(OP_WR, 32'h0000_1000, 32'h0f0f_0f0f, 32'h0, 1'b0);
    add_entry(OP_WR, 32'h0001_0004, 32'hf0f0_f0f0, 32'h0, 1'b0);
    add_entry(OP_RD, 32'h0000_0008, 32'h0, 32'd4, 1'b0);
    add_entry(OP_RD, 32'h0000_0004, 32'h0, 32'h4444_0003, 1'b0);
    add_entry(OP_RD, 32'h0000_0108, 32'h0, 32'd2, 1'b0);
    add_entry(OP_RD, 32'h0000_0208, 32'h0, 32'd3, 1'b0);
    // FLR while idle
    add_entry(OP_RD, 32'h0000_0000, 32'h0, 32'h1111_0000, 1'b1);
    add_entry(OP_WR, 32'h0000_0104, 32'h7777_0006, 32'h0, 1'b1);
    add_entry(OP_RD, 32'h0000_0104, 32'h0, 32'h7777_0006, 1'b0);
    add_entry(OP_RD, 32'h0000_0108, 32'h0, 32'd3, 1'b0);
    add_entry(OP_RD, 32'h0000_010c, 32'h0, 32'h0000_b001, 1'b1);
  endtask

  // ------------------------------
  // Main sequence
  // ------------------------------
  initial
  begin
    ocl_mosi   = '0;
    flr_assert = 1'b0;
    load_table();
    table_loaded = 1'b1;
    wait (sync_rst_n);
    next_cycle();
    foreach (tbl[i])
    begin
      if (tbl[i].flr)
        pulse_flr();
      if (tbl[i].op == OP_WR)
        axil_write(tbl[i].addr, tbl[i].wdata);
      else
        axil_read(tbl[i].addr, tbl[i].exp);
    end
    $display("Verification passed");
    $finish;
  end

  // Watchdog scaled by table length
  initial
  begin
    wait (table_loaded);
    repeat (tbl.size() * CYCLES_PER_ROW) @(posedge clk);
    $display("Verification failed");
    $fatal(1, "Timeout: the table did not finish within %0d cycles",
           tbl.size() * CYCLES_PER_ROW);
  end

endmodule

// ==== vlog.f ====
src/ocl_axil_pkg.sv
src/ocl_cfg_pkg.sv
src/axil_reg_slice.sv
src/ocl_cfg_slv.sv
src/tst_cfg_regs.sv
src/cl_ocl_top.sv
sim/tb_clk_gen.sv
sim/tb_cl_ocl.sv

// ==== Makefile ====
# Verilator build and run of the register access path testbench

VERILATOR ?= verilator
TOP       ?= tb_cl_ocl
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list targets and variables"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
